// ==== exec_ops_pkg.sv ====
// operation, size and sequencer encodings, imported by the execution RTL and its testbench
`default_nettype none

package exec_ops_pkg;

    typedef enum logic [3:0] {
        op_nop, op_ld_imm, op_ld_reg,
        op_add, op_sub, op_and, op_xor,
        op_store, op_push, op_pop,
        op_ldi, op_ldir,
        op_inc_rfp, op_dec_rfp, op_ld_rfp
    } exec_op_t;

    // write width and pointer step of 1, 2 or 4
    typedef enum logic [1:0] {
        sz_byte, sz_word, sz_long
    } op_size_t;

    typedef enum logic [2:0] {
        st_idle, st_exec, st_mem_rd, st_mem_wr, st_done
    } seq_state_t;

    // register writeback source, also the RAM write data
    localparam logic [1:0] WB_IMM = 2'd0;
    localparam logic [1:0] WB_SRC = 2'd1;
    localparam logic [1:0] WB_ALU = 2'd2;
    localparam logic [1:0] WB_RAM = 2'd3;

    // RAM byte address source
    localparam logic [1:0] ADDR_DST = 2'd0;
    localparam logic [1:0] ADDR_XSP = 2'd1;
    localparam logic [1:0] ADDR_XHL = 2'd2;
    localparam logic [1:0] ADDR_XDE = 2'd3;

endpackage

`default_nettype wire

// ==== reg_map_pkg.sv ====
// register code fields and dump address map, imported by the register file, sequencer and testbench
`default_nettype none

package reg_map_pkg;

    // high nibble picks the bank or pointer space, low nibble the byte
    typedef logic [7:0] reg_code_t;

    localparam logic [3:0] BANK_PREV = 4'hd;
    localparam logic [3:0] BANK_CUR  = 4'he;
    localparam logic [3:0] PTR_SPACE = 4'hf;

    // byte 0 of each register, current bank
    localparam reg_code_t RC_XWA = 8'he0;
    localparam reg_code_t RC_XBC = 8'he4;
    localparam reg_code_t RC_XDE = 8'he8;
    localparam reg_code_t RC_XHL = 8'hec;
    localparam reg_code_t RC_XIX = 8'hf0;
    localparam reg_code_t RC_XIY = 8'hf4;
    localparam reg_code_t RC_XIZ = 8'hf8;
    localparam reg_code_t RC_XSP = 8'hfc;

    // dump port: accumulators, then pointers, then rfp and flags
    localparam logic [7:0] DMP_ACC_END = 8'h40;
    localparam logic [7:0] DMP_PTR_END = 8'h50;
    localparam logic [7:0] DMP_FLAGS   = 8'h50;

endpackage

`default_nettype wire

// ==== bank_regs.sv ====
// banked accumulator and pointer file with rfp, pointer stepping, writeback and byte dump port
`timescale 1ns/1ps
`default_nettype none

module bank_regs (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cen,
    input  wire reg_map_pkg::reg_code_t src_code,
    input  wire reg_map_pkg::reg_code_t dst_code,
    input  wire exec_ops_pkg::op_size_t wr_size,
    input  wire logic                   wr_en,
    input  wire logic [31:0]            wr_data,
    input  wire logic                   inc_rfp,
    input  wire logic                   dec_rfp,
    input  wire logic                   rfp_we,
    input  wire logic [1:0]             rfp_imm,
    input  wire exec_ops_pkg::op_size_t reg_step,
    input  wire logic                   inc_xhl,
    input  wire logic                   inc_xde,
    input  wire logic                   dec_bc,
    input  wire logic                   dec_xsp,
    input  wire logic                   inc_xsp,
    input  wire logic [1:0]             flags,
    input  wire logic [7:0]             dmp_addr,
    output logic [31:0]                 src_out,
    output logic [31:0]                 dst_out,
    output logic [31:0]                 xhl,
    output logic [31:0]                 xde,
    output logic [31:0]                 xsp,
    output logic                        bc_unity,
    output logic [7:0]                  dmp_dout
);
    import exec_ops_pkg::*;
    import reg_map_pkg::*;

    localparam logic [6:0] XSP_BASE = 7'h4c;

    // bytes 0..63 are {bank, byte}, pointer bytes follow from 64
    logic [7:0]  rf [0:79];
    logic [1:0]  rfp;
    logic [6:0]  src_idx, dst_idx;
    logic [6:0]  xhl_base, xde_base, xbc_base;
    logic [31:0] xbc, step;
    logic [31:0] xhl_next, xde_next, xsp_next;

    // current and previous bank codes become a direct bank
    function automatic logic [6:0] resolve(input logic [1:0] bank_ptr, input reg_code_t code);
        logic [1:0] bank;
        bank = code[5:4];
        if (code[7:4] == PTR_SPACE)
            return {3'b100, code[3:0]};
        if (code[7:4] == BANK_CUR)
            bank = bank_ptr;
        else if (code[7:4] == BANK_PREV)
            bank = bank_ptr - 2'd1;
        return {1'b0, bank, code[3:0]};
    endfunction

    // byte k of an operand: low pair follows the code, upper pair stays long aligned
    function automatic logic [6:0] lane(input logic [6:0] idx, input int k);
        case (k)
            0:       return idx;
            1:       return {idx[6:1], 1'b1};
            2:       return {idx[6:2], 2'd2};
            default: return {idx[6:2], 2'd3};
        endcase
    endfunction

    function automatic logic [31:0] long_at(input logic [6:0] base);
        return {rf[base | 7'd3], rf[base | 7'd2], rf[base | 7'd1], rf[base]};
    endfunction

    assign src_idx  = resolve(rfp, src_code);
    assign dst_idx  = resolve(rfp, dst_code);
    assign xbc_base = {1'b0, rfp, 4'h4};
    assign xde_base = {1'b0, rfp, 4'h8};
    assign xhl_base = {1'b0, rfp, 4'hc};

    always_comb begin
        for (int k = 0; k < 4; k++) begin
            src_out[8*k +: 8] = rf[lane(src_idx, k)];
            dst_out[8*k +: 8] = rf[lane(dst_idx, k)];
        end
        xbc = long_at(xbc_base);
        xde = long_at(xde_base);
        xhl = long_at(xhl_base);
        xsp = long_at(XSP_BASE);
    end

    always_comb begin
        case (reg_step)
            sz_byte: step = 32'd1;
            sz_word: step = 32'd2;
            default: step = 32'd4;
        endcase
    end

    assign xhl_next = xhl + step;
    assign xde_next = xde + step;
    assign xsp_next = dec_xsp ? xsp - step : xsp + step;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < 80; i++) begin
                rf[i] <= 8'd0;
            end
            rfp      <= 2'd0;
            bc_unity <= 1'b0;
        end else if (cen) begin
            bc_unity <= xbc[15:0] == 16'd1;
            if (rfp_we)
                rfp <= rfp_imm;
            else if (inc_rfp)
                rfp <= rfp + 2'd1;
            else if (dec_rfp)
                rfp <= rfp - 2'd1;
            for (int k = 0; k < 4; k++) begin
                if (inc_xhl)
                    rf[xhl_base | 7'(k)] <= xhl_next[8*k +: 8];
                if (inc_xde)
                    rf[xde_base | 7'(k)] <= xde_next[8*k +: 8];
                if (dec_xsp || inc_xsp)
                    rf[XSP_BASE | 7'(k)] <= xsp_next[8*k +: 8];
            end
            // only the low word of xbc counts
            if (dec_bc) begin
                rf[xbc_base]         <= xbc[7:0] - 8'd1;
                rf[xbc_base | 7'd1]  <= xbc[15:8] - {7'd0, xbc[7:0] == 8'd0};
            end
            if (wr_en) begin
                rf[dst_idx] <= wr_data[7:0];
                if (wr_size != sz_byte)
                    rf[lane(dst_idx, 1)] <= wr_data[15:8];
                if (wr_size == sz_long) begin
                    rf[lane(dst_idx, 2)] <= wr_data[23:16];
                    rf[lane(dst_idx, 3)] <= wr_data[31:24];
                end
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dmp_dout <= 8'd0;
        end else if (cen) begin
            if (dmp_addr < DMP_ACC_END)
                dmp_dout <= rf[{1'b0, dmp_addr[5:0]}];
            else if (dmp_addr < DMP_PTR_END)
                dmp_dout <= rf[{3'b100, dmp_addr[3:0]}];
            else if (dmp_addr == DMP_FLAGS)
                dmp_dout <= {2'b00, rfp, 2'b00, flags};
            else
                dmp_dout <= 8'd0;
        end
    end

endmodule

`default_nettype wire

// ==== exec_alu.sv ====
// width-aware add, sub, and, xor with registered zero and carry flags
`timescale 1ns/1ps
`default_nettype none

module exec_alu (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cen,
    input  wire exec_ops_pkg::exec_op_t op,
    input  wire exec_ops_pkg::op_size_t size,
    input  wire logic [31:0]            a,
    input  wire logic [31:0]            b,
    input  wire logic                   flag_we,
    output logic [31:0]                 alu_out,
    output logic [1:0]                  flags
);
    import exec_ops_pkg::*;

    logic [31:0] mask, am, bm;
    logic [32:0] wide;
    logic        carry;

    always_comb begin
        case (size)
            sz_byte: mask = 32'h0000_00ff;
            sz_word: mask = 32'h0000_ffff;
            default: mask = 32'hffff_ffff;
        endcase
        am = a & mask;
        bm = b & mask;
        case (op)
            op_add:  wide = {1'b0, am} + {1'b0, bm};
            op_sub:  wide = {1'b0, am} - {1'b0, bm};
            op_and:  wide = {1'b0, am & bm};
            default: wide = {1'b0, am ^ bm};
        endcase
        alu_out = wide[31:0] & mask;
        // borrow sets every bit above the width, so one tap serves add and sub
        case (size)
            sz_byte: carry = wide[8];
            sz_word: carry = wide[16];
            default: carry = wide[32];
        endcase
    end

    // flags = {zero, carry}
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            flags <= 2'b00;
        else if (cen && flag_we)
            flags <= {alu_out == 32'd0, carry};
    end

endmodule

`default_nettype wire

// ==== data_ram.sv ====
// long-word data RAM addressed by byte, registered read, write on the clock edge
`timescale 1ns/1ps
`default_nettype none

module data_ram #(
    parameter int RAM_AW = 6
) (
    input  wire logic        clk,
    input  wire logic        we,
    input  wire logic [31:0] addr,
    input  wire logic [31:0] wdata,
    output logic [31:0]      rdata
);
    logic [31:0]       mem [0:(1 << RAM_AW) - 1];
    logic [RAM_AW-1:0] word_idx;

    // byte address wraps at the RAM size, bits 1:0 drop
    assign word_idx = addr[RAM_AW+1:2];

    // read data holds during writes so a block move keeps its long
    always_ff @(posedge clk) begin
        if (we)
            mem[word_idx] <= wdata;
        else
            rdata <= mem[word_idx];
    end

endmodule

`default_nettype wire

// ==== op_sequencer.sv ====
// command capture FSM driving register file, alu and RAM strobes one cycle each
`timescale 1ns/1ps
`default_nettype none

module op_sequencer (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cen,
    input  wire logic                   cmd_valid,
    input  wire exec_ops_pkg::exec_op_t cmd_op,
    input  wire reg_map_pkg::reg_code_t cmd_dst,
    input  wire reg_map_pkg::reg_code_t cmd_src,
    input  wire logic [31:0]            cmd_imm,
    input  wire exec_ops_pkg::op_size_t cmd_size,
    input  wire logic                   bc_unity,
    output logic                        busy,
    output logic                        done,
    output reg_map_pkg::reg_code_t      src_code,
    output reg_map_pkg::reg_code_t      dst_code,
    output exec_ops_pkg::op_size_t      wr_size,
    output logic                        wr_en,
    output logic [1:0]                  wr_sel,
    output exec_ops_pkg::op_size_t      reg_step,
    output logic                        inc_xhl,
    output logic                        inc_xde,
    output logic                        dec_bc,
    output logic                        dec_xsp,
    output logic                        inc_xsp,
    output logic                        inc_rfp,
    output logic                        dec_rfp,
    output logic                        rfp_we,
    output logic [1:0]                  rfp_imm,
    output exec_ops_pkg::exec_op_t      alu_op,
    output logic                        flag_we,
    output logic                        ram_we,
    output logic [1:0]                  ram_addr_sel
);
    import exec_ops_pkg::*;
    import reg_map_pkg::*;

    seq_state_t state;
    exec_op_t   op_q;
    reg_code_t  dst_q, src_q;
    op_size_t   size_q;
    logic       is_alu, is_blk, is_stack;

    assign is_alu   = op_q inside {op_add, op_sub, op_and, op_xor};
    assign is_blk   = op_q inside {op_ldi, op_ldir};
    assign is_stack = op_q inside {op_push, op_pop};

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state   <= st_idle;
            op_q    <= op_nop;
            dst_q   <= 8'd0;
            src_q   <= 8'd0;
            size_q  <= sz_byte;
            rfp_imm <= 2'd0;
        end else if (cen) begin
            case (state)
                st_idle: if (cmd_valid) begin
                    op_q    <= cmd_op;
                    dst_q   <= cmd_dst;
                    src_q   <= cmd_src;
                    size_q  <= cmd_size;
                    rfp_imm <= cmd_imm[1:0];
                    if (cmd_op == op_store)
                        state <= st_mem_wr;
                    else if (cmd_op inside {op_pop, op_ldi, op_ldir})
                        state <= st_mem_rd;
                    else
                        state <= st_exec;
                end
                st_exec:   state <= (op_q == op_push) ? st_mem_wr : st_done;
                st_mem_rd: state <= (op_q == op_pop) ? st_exec : st_mem_wr;
                // ldir loops until the count seen before this decrement was 1
                st_mem_wr: state <= (op_q == op_ldir && !bc_unity) ? st_mem_rd : st_done;
                default:   state <= st_idle;
            endcase
        end
    end

    assign busy = state != st_idle;
    assign done = state == st_done;

    // block moves walk xhl to xde, stack ops work on xsp
    assign src_code = is_blk ? RC_XHL : (op_q == op_pop) ? RC_XSP : src_q;
    assign dst_code = is_blk ? RC_XDE : (op_q == op_push) ? RC_XSP : dst_q;
    assign wr_size  = (op_q == op_pop) ? sz_long : size_q;
    assign reg_step = (is_blk || is_stack) ? sz_long : size_q;

    assign wr_en   = state == st_exec && (is_alu || op_q inside {op_ld_imm, op_ld_reg, op_pop});
    assign flag_we = state == st_exec && is_alu;
    assign alu_op  = op_q;
    assign inc_rfp = state == st_exec && op_q == op_inc_rfp;
    assign dec_rfp = state == st_exec && op_q == op_dec_rfp;
    assign rfp_we  = state == st_exec && op_q == op_ld_rfp;
    assign dec_xsp = state == st_exec && op_q == op_push;
    assign inc_xsp = state == st_exec && op_q == op_pop;
    assign inc_xhl = state == st_mem_wr && is_blk;
    assign inc_xde = state == st_mem_wr && is_blk;
    assign dec_bc  = state == st_mem_wr && is_blk;
    assign ram_we  = state == st_mem_wr;

    always_comb begin
        case (op_q)
            op_ld_imm:                  wr_sel = WB_IMM;
            op_add, op_sub, op_and,
            op_xor:                     wr_sel = WB_ALU;
            op_pop, op_ldi, op_ldir:    wr_sel = WB_RAM;
            default:                    wr_sel = WB_SRC;
        endcase
        if (is_blk)
            ram_addr_sel = (state == st_mem_rd) ? ADDR_XHL : ADDR_XDE;
        else if (is_stack)
            ram_addr_sel = ADDR_XSP;
        else
            ram_addr_sel = ADDR_DST;
    end

endmodule

`default_nettype wire

// ==== exec_core.sv ====
// execution subsystem top, wires the sequencer, register file, alu and data RAM together
`timescale 1ns/1ps
`default_nettype none

module exec_core #(
    parameter int RAM_AW = 6
) (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   cen,
    input  wire logic                   cmd_valid,
    input  wire exec_ops_pkg::exec_op_t cmd_op,
    input  wire logic [7:0]             cmd_dst,
    input  wire logic [7:0]             cmd_src,
    input  wire logic [31:0]            cmd_imm,
    input  wire exec_ops_pkg::op_size_t cmd_size,
    input  wire logic [7:0]             dmp_addr,
    output logic                        busy,
    output logic                        done,
    output logic [7:0]                  dmp_dout
);
    import exec_ops_pkg::*;
    import reg_map_pkg::*;

    reg_code_t   src_code, dst_code;
    op_size_t    wr_size, reg_step;
    exec_op_t    alu_op;
    logic        wr_en, inc_xhl, inc_xde, dec_bc, dec_xsp, inc_xsp;
    logic        inc_rfp, dec_rfp, rfp_we, flag_we, ram_we, bc_unity;
    logic [1:0]  wr_sel, ram_addr_sel, rfp_imm, flags;
    logic [31:0] imm_q, wr_data, ram_addr;
    logic [31:0] src_out, dst_out, xhl, xde, xsp, alu_out, ram_dout;

    // immediate held for the writeback cycle
    always_ff @(posedge clk) begin
        if (cen && cmd_valid && !busy)
            imm_q <= cmd_imm;
    end

    // writeback data doubles as RAM write data
    always_comb begin
        case (wr_sel)
            WB_IMM:  wr_data = imm_q;
            WB_SRC:  wr_data = src_out;
            WB_ALU:  wr_data = alu_out;
            default: wr_data = ram_dout;
        endcase
        case (ram_addr_sel)
            ADDR_XSP: ram_addr = xsp;
            ADDR_XHL: ram_addr = xhl;
            ADDR_XDE: ram_addr = xde;
            default:  ram_addr = dst_out;
        endcase
    end

    op_sequencer u_seq (
        .clk(clk), .rst(rst), .cen(cen),
        .cmd_valid(cmd_valid), .cmd_op(cmd_op), .cmd_dst(cmd_dst),
        .cmd_src(cmd_src), .cmd_imm(cmd_imm), .cmd_size(cmd_size),
        .bc_unity(bc_unity), .busy(busy), .done(done),
        .src_code(src_code), .dst_code(dst_code), .wr_size(wr_size),
        .wr_en(wr_en), .wr_sel(wr_sel), .reg_step(reg_step),
        .inc_xhl(inc_xhl), .inc_xde(inc_xde), .dec_bc(dec_bc),
        .dec_xsp(dec_xsp), .inc_xsp(inc_xsp), .inc_rfp(inc_rfp),
        .dec_rfp(dec_rfp), .rfp_we(rfp_we), .rfp_imm(rfp_imm),
        .alu_op(alu_op), .flag_we(flag_we), .ram_we(ram_we),
        .ram_addr_sel(ram_addr_sel)
    );

    bank_regs u_regs (
        .clk(clk), .rst(rst), .cen(cen),
        .src_code(src_code), .dst_code(dst_code), .wr_size(wr_size),
        .wr_en(wr_en), .wr_data(wr_data), .inc_rfp(inc_rfp),
        .dec_rfp(dec_rfp), .rfp_we(rfp_we), .rfp_imm(rfp_imm),
        .reg_step(reg_step), .inc_xhl(inc_xhl), .inc_xde(inc_xde),
        .dec_bc(dec_bc), .dec_xsp(dec_xsp), .inc_xsp(inc_xsp),
        .flags(flags), .dmp_addr(dmp_addr), .src_out(src_out),
        .dst_out(dst_out), .xhl(xhl), .xde(xde), .xsp(xsp),
        .bc_unity(bc_unity), .dmp_dout(dmp_dout)
    );

    exec_alu u_alu (
        .clk(clk), .rst(rst), .cen(cen), .op(alu_op), .size(wr_size),
        .a(dst_out), .b(src_out), .flag_we(flag_we),
        .alu_out(alu_out), .flags(flags)
    );

    data_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk(clk), .we(ram_we), .addr(ram_addr), .wdata(wr_data), .rdata(ram_dout)
    );

endmodule

`default_nettype wire

// ==== tb_exec_core.sv ====
// self-checking testbench for exec_core, replays exec_golden.txt and checks through the dump port
`timescale 1ns/1ps
`default_nettype none

module tb_exec_core;
    import exec_ops_pkg::*;
    import reg_map_pkg::*;

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        cen = 1'b1;
    logic        cmd_valid = 1'b0;
    exec_op_t    cmd_op = op_nop;
    logic [7:0]  cmd_dst = 8'd0;
    logic [7:0]  cmd_src = 8'd0;
    logic [31:0] cmd_imm = 32'd0;
    op_size_t    cmd_size = sz_byte;
    logic [7:0]  dmp_addr = 8'd0;
    wire logic   busy;
    wire logic   done;
    wire logic [7:0] dmp_dout;

    integer seed = 76;
    integer fd, n, mode, r, gap;
    integer checks = 0, errors = 0, tests = 0;
    integer test_checks = 0, test_errors = 0;
    bit     cen_random = 1'b0;
    bit     hold_cen = 1'b0;
    bit     aborted = 1'b0;
    string  line, tname;
    byte    kind;
    logic [31:0] f_op, f_dst, f_src, f_imm, f_size, f_addr, f_val;

    exec_core #(.RAM_AW(6)) UUT (
        .clk(clk), .rst(rst), .cen(cen), .cmd_valid(cmd_valid), .cmd_op(cmd_op),
        .cmd_dst(cmd_dst), .cmd_src(cmd_src), .cmd_imm(cmd_imm), .cmd_size(cmd_size),
        .dmp_addr(dmp_addr), .busy(busy), .done(done), .dmp_dout(dmp_dout)
    );

    always #2 clk = ~clk;

    task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("[FAIL] %0d ns %0s got %h expected %h", $time, name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic flag_timeout(input string why);
        $display("%0s", why);
        aborted = 1'b1;
    endtask

    // one rising edge, cen pseudo-random unless held high
    task automatic tick();
        integer v;
        @(posedge clk);
        v = $random(seed);
        if (cen_random && !hold_cen)
            cen <= v[0];
        else
            cen <= 1'b1;
    endtask

    task automatic wait_idle();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < 200 && !seen; i++) begin
            tick();
            @(negedge clk);
            seen = !busy;
        end
        if (!seen)
            flag_timeout("DUT stayed busy for 200 cycles before a new command");
    endtask

    task automatic wait_done();
        bit seen;
        seen = 1'b0;
        for (int i = 0; i < 200 && !seen; i++) begin
            @(negedge clk);
            seen = done;
            if (!seen)
                tick();
        end
        if (!seen)
            flag_timeout("no done pulse within 200 cycles of a command");
    endtask

    // inject drives a second command in the cycle after capture, while busy
    task automatic issue_cmd(input logic [31:0] op, input logic [7:0] dst, input logic [7:0] src,
                             input logic [31:0] imm, input logic [31:0] size, input bit inject);
        hold_cen = 1'b1;
        wait_idle();
        if (!aborted) begin
            tick();
            cmd_valid <= 1'b1;
            cmd_op    <= exec_op_t'(op[3:0]);
            cmd_dst   <= dst;
            cmd_src   <= src;
            cmd_imm   <= imm;
            cmd_size  <= op_size_t'(size[1:0]);
            tick();
            if (inject) begin
                cmd_op   <= op_ld_imm;
                cmd_dst  <= RC_XWA;
                cmd_imm  <= 32'hdead_beef;
                cmd_size <= sz_long;
            end else begin
                cmd_valid <= 1'b0;
            end
            // busy rises on capture, done only comes at the end
            @(negedge clk);
            check_val("busy", {31'd0, busy}, 32'd1);
            check_val("done", {31'd0, done}, 32'd0);
            if (inject) begin
                tick();
                cmd_valid <= 1'b0;
            end
            hold_cen = 1'b0;
            wait_done();
        end
        hold_cen = 1'b0;
    endtask

    task automatic dump_check(input logic [7:0] addr, input logic [7:0] exp);
        hold_cen = 1'b1;
        tick();
        dmp_addr <= addr;
        tick();
        @(negedge clk);
        check_val($sformatf("dmp_dout[%02h]", addr), {24'd0, dmp_dout}, {24'd0, exp});
        hold_cen = 1'b0;
    endtask

    task automatic close_test();
        if (tests > 0)
            $display("test %0s: %0d checks, %0d errors", tname, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    initial begin
        repeat (3) @(posedge clk);
        rst <= 1'b0;
        fd = $fopen("exec_golden.txt", "r");
        if (fd == 0) begin
            $display("cannot open the golden file exec_golden.txt");
            aborted = 1'b1;
        end else begin
            mode = 0;
            while (!$feof(fd) && !aborted) begin
                line = "";
                n = $fgets(line, fd);
                if (n == 0 || line.len() == 0)
                    continue;
                kind = line.getc(0);
                if (kind == "T") begin
                    close_test();
                    n = $sscanf(line, "T %s %d", tname, mode);
                    tests++;
                    cen_random = (mode == 1);
                end else if (kind == "C") begin
                    n = $sscanf(line, "C %h %h %h %h %h", f_op, f_dst, f_src, f_imm, f_size);
                    issue_cmd(f_op, f_dst[7:0], f_src[7:0], f_imm, f_size, mode == 2);
                    r = $random(seed);
                    gap = {30'd0, r[1:0]};
                    repeat (gap) tick();
                end else if (kind == "D") begin
                    n = $sscanf(line, "D %h %h", f_addr, f_val);
                    dump_check(f_addr[7:0], f_val[7:0]);
                end
            end
            $fclose(fd);
        end
        close_test();
        $display("tests=%0d checks=%0d errors=%0d", tests, checks, errors);
        if (errors == 0 && checks > 0 && !aborted)
            $display("sim passed");
        else
            $display("sim failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== exec_golden.txt ====
# T name mode (0 plain, 1 random cen, 2 extra command while busy)
# C op dst src imm size (hex) | D dump_addr expected_byte (hex)
T load 0
C 1 e0 00 11223344 2
D 00 44
D 03 11
C 1 e0 00 000000aa 0
D 00 aa
D 01 33
D 03 11
C 1 e4 00 0000beef 1
D 04 ef
D 05 be
D 06 00
T bank 0
C e 00 00 00000002 0
D 50 20
C 1 e8 00 cafef00d 2
D 28 0d
D 2b ca
C c 00 00 00000000 0
D 50 30
C 2 e0 d8 00000000 2
D 30 0d
D 33 ca
C d 00 00 00000000 0
D 50 20
C e 00 00 00000000 0
D 50 00
T alu 0
C 1 e8 00 000000f0 2
C 1 ec 00 00000020 2
C 3 e8 ec 00000000 0
D 08 10
D 50 01
C 4 ec e8 00000000 1
D 0c 10
D 0d 00
D 50 00
C 5 e0 ec 00000000 2
D 00 00
D 03 00
D 50 02
C 6 e4 e8 00000000 2
D 04 ff
D 05 be
D 50 00
C 4 e8 e4 00000000 0
D 08 11
D 50 01
T stack 0
C 1 fc 00 00000080 2
D 4c 80
C 1 f0 00 00000040 2
C 7 f0 e4 00000000 2
C 1 e0 00 5a5a1234 2
C 8 00 e0 00000000 2
D 4c 7c
C 9 e8 00 00000000 2
D 08 34
D 0b 5a
D 4c 80
C 1 fc 00 00000040 2
C 9 ec 00 00000000 2
D 0c ff
D 0d be
D 0e 00
D 4c 44
T blkmove 0
C 1 e0 00 a1a1a1a1 2
C 1 f0 00 00000090 2
C 7 f0 e0 00000000 2
C 1 e0 00 b2b2b2b2 2
C 1 f0 00 00000094 2
C 7 f0 e0 00000000 2
C 1 e0 00 c3c3c3c3 2
C 1 f0 00 00000098 2
C 7 f0 e0 00000000 2
C 1 ec 00 00000090 2
C 1 e8 00 000000c0 2
C 1 e4 00 00000001 2
C a 00 00 00000000 2
C 1 e4 00 00000002 2
C b 00 00 00000000 2
D 0c 9c
D 08 cc
D 04 00
D 05 00
C 1 fc 00 000000c0 2
C 9 e0 00 00000000 2
D 00 a1
C 9 e0 00 00000000 2
D 00 b2
C 9 e0 00 00000000 2
D 00 c3
D 4c cc
T blkcen 1
C 1 ec 00 00000090 2
C 1 e8 00 000000e0 2
C 1 e4 00 00000003 2
C b 00 00 00000000 2
D 0c 9c
D 08 ec
D 04 00
C 1 fc 00 000000e0 2
C 9 e0 00 00000000 2
D 00 a1
C 9 e0 00 00000000 2
D 00 b2
C 9 e0 00 00000000 2
D 00 c3
D 4c ec
T busy 2
C 1 e4 00 12345678 2
D 04 78
D 07 12
D 00 c3
D 03 c3

// ==== build.f ====
exec_ops_pkg.sv
reg_map_pkg.sv
bank_regs.sv
exec_alu.sv
data_ram.sv
op_sequencer.sv
exec_core.sv
tb_exec_core.sv

// ==== run_sim.sh ====
#!/bin/bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing -f build.f --top-module tb_exec_core -o sim_exec > build.log 2>&1 \
    || { echo "build failed, see build.log"; exit 1; }
./obj_dir/sim_exec > sim.log 2>&1
grep -q "^sim passed$" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
